//--- vseq_pkg.sv
package vseq_pkg;

  ////////////////////
  // Processing elements
  ////////////////////

  localparam int unsigned NR_LANES  = 2;
  localparam int unsigned NR_PES    = NR_LANES + 2;
  // Non-lane PEs sit right after the lanes
  localparam int unsigned PE_MEM    = NR_LANES;
  localparam int unsigned PE_SCALAR = NR_LANES + 1;

  // Instructions in flight and register file size
  localparam int unsigned NR_VINSN = 4;
  localparam int unsigned NR_VREGS = 32;

  ////////////////////
  // Memory access
  ////////////////////

  localparam int unsigned ELEM_BYTES = 4;
  localparam int unsigned OFFS_W     = $clog2(ELEM_BYTES);
  localparam int unsigned ADDR_LAT   = 2;
  localparam int unsigned LAT_W      = $clog2(ADDR_LAT + 1);

  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;
  typedef logic [7:0]                  vlen_t;

  typedef enum logic [1:0] {
    VADD,
    VLD,
    VST,
    VPOPC
  } vseq_op_e;

  typedef enum logic [1:0] {
    UNIT_LANES,
    UNIT_MEM,
    UNIT_SCALAR
  } vseq_unit_e;

  // Base address for loads and stores, bit mask for popcount
  typedef union packed {
    logic [31:0] addr;
    logic [31:0] mask;
  } vseq_operand_u;

  function automatic vseq_unit_e unit_of(vseq_op_e op);
    unique case (op)
      VLD, VST: unit_of = UNIT_MEM;
      VPOPC:    unit_of = UNIT_SCALAR;
      default:  unit_of = UNIT_LANES;
    endcase
  endfunction

endpackage

//--- vseq_lane.sv
`timescale 1ns/100ps

module vseq_lane (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          pe_req_valid_i,
  input  vseq_pkg::vseq_op_e            pe_op_i,
  input  vseq_pkg::vid_t                pe_id_i,
  input  vseq_pkg::vlen_t               pe_vl_i,
  input  logic [vseq_pkg::NR_VINSN-1:0] pe_hazard_i,
  input  logic [vseq_pkg::NR_VINSN-1:0] vinsn_running_i,
  output logic                          ready_o,
  output logic [vseq_pkg::NR_VINSN-1:0] done_o
);

  import vseq_pkg::*;

  logic                busy_q;
  vid_t                id_q;
  vlen_t               cnt_q;
  logic [NR_VINSN-1:0] hazard_q;
  logic                take, clear, last;
  vlen_t               share;

  // Elements handled by this lane, rounded up
  assign share = vlen_t'((32'(pe_vl_i) + NR_LANES - 1) / NR_LANES);

  assign ready_o = !busy_q;

  // A finished id is no longer running, so a held broadcast is not run twice
  assign take = pe_req_valid_i && ready_o && unit_of(pe_op_i) == UNIT_LANES &&
                vinsn_running_i[pe_id_i];

  assign clear  = ~|(hazard_q & vinsn_running_i);
  assign last   = busy_q && clear && cnt_q == vlen_t'(1);
  assign done_o = last ? (NR_VINSN'(1) << id_q) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (take) begin
      busy_q <= 1'b1;
    end else if (last) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      id_q     <= pe_id_i;
      cnt_q    <= (share == '0) ? vlen_t'(1) : share;
      hazard_q <= pe_hazard_i;
    end else begin
      // Hazards drop out as the older instructions finish
      hazard_q <= hazard_q & vinsn_running_i;
      if (busy_q && clear) cnt_q <= cnt_q - vlen_t'(1);
    end
  end

  // Done only from a busy lane, and only for an id the sequencer still runs
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    |done_o |-> busy_q && ((done_o & vinsn_running_i) == done_o));

endmodule

//--- vseq_mem_unit.sv
`timescale 1ns/100ps

module vseq_mem_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          pe_req_valid_i,
  input  vseq_pkg::vseq_op_e            pe_op_i,
  input  vseq_pkg::vid_t                pe_id_i,
  input  vseq_pkg::vlen_t               pe_vl_i,
  input  vseq_pkg::vseq_operand_u       pe_operand_i,
  input  logic [vseq_pkg::NR_VINSN-1:0] pe_hazard_i,
  input  logic [vseq_pkg::NR_VINSN-1:0] vinsn_running_i,
  output logic                          ready_o,
  output logic [vseq_pkg::NR_VINSN-1:0] done_o,
  output logic                          addr_ack_o,
  output logic                          addr_error_o
);

  import vseq_pkg::*;

  logic                busy_q, addr_q, err_q;
  vid_t                id_q;
  vlen_t               cnt_q;
  logic [LAT_W-1:0]    lat_q;
  logic [NR_VINSN-1:0] hazard_q;
  logic                take, clear, last;

  assign ready_o = !busy_q;
  assign take    = pe_req_valid_i && ready_o && unit_of(pe_op_i) == UNIT_MEM &&
                   vinsn_running_i[pe_id_i];
  assign clear   = ~|(hazard_q & vinsn_running_i);

  // Address phase ends with the acknowledge
  assign addr_ack_o   = busy_q && addr_q && lat_q == '0;
  assign addr_error_o = addr_ack_o && err_q;

  // Misaligned accesses finish right at the acknowledge
  assign last   = addr_error_o || (busy_q && !addr_q && clear && cnt_q == vlen_t'(1));
  assign done_o = last ? (NR_VINSN'(1) << id_q) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      addr_q <= 1'b0;
    end else if (take) begin
      busy_q <= 1'b1;
      addr_q <= 1'b1;
    end else begin
      if (addr_ack_o) addr_q <= 1'b0;
      if (last) busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      id_q     <= pe_id_i;
      err_q    <= pe_operand_i.addr[OFFS_W-1:0] != '0;
      lat_q    <= LAT_W'(ADDR_LAT - 1);
      cnt_q    <= (pe_vl_i == '0) ? vlen_t'(1) : pe_vl_i;
      hazard_q <= pe_hazard_i;
    end else begin
      hazard_q <= hazard_q & vinsn_running_i;
      if (addr_q && lat_q != '0) lat_q <= lat_q - LAT_W'(1);
      // One element per cycle once the source data is ready
      if (busy_q && !addr_q && clear) cnt_q <= cnt_q - vlen_t'(1);
    end
  end

endmodule

//--- vseq_scalar_unit.sv
`timescale 1ns/100ps

module vseq_scalar_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          pe_req_valid_i,
  input  vseq_pkg::vseq_op_e            pe_op_i,
  input  vseq_pkg::vid_t                pe_id_i,
  input  vseq_pkg::vlen_t               pe_vl_i,
  input  vseq_pkg::vseq_operand_u       pe_operand_i,
  input  logic [vseq_pkg::NR_VINSN-1:0] pe_hazard_i,
  input  logic [vseq_pkg::NR_VINSN-1:0] vinsn_running_i,
  output logic                          ready_o,
  output logic [vseq_pkg::NR_VINSN-1:0] done_o,
  output logic                          scalar_valid_o,
  output logic [31:0]                   scalar_data_o
);

  import vseq_pkg::*;

  logic                busy_q;
  vid_t                id_q;
  vlen_t               rem_q;
  logic [31:0]         mask_q, count_q;
  logic [NR_VINSN-1:0] hazard_q;
  logic                take, clear, fin;

  assign ready_o = !busy_q;
  assign take    = pe_req_valid_i && ready_o && unit_of(pe_op_i) == UNIT_SCALAR &&
                   vinsn_running_i[pe_id_i];
  assign clear   = ~|(hazard_q & vinsn_running_i);

  // The last bit is added on the way out, so vl cycles suffice
  assign fin            = busy_q && clear && rem_q <= vlen_t'(1);
  assign scalar_valid_o = fin;
  assign scalar_data_o  = count_q + 32'(rem_q != '0 && mask_q[0]);
  assign done_o         = fin ? (NR_VINSN'(1) << id_q) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (take) begin
      busy_q <= 1'b1;
    end else if (fin) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      id_q     <= pe_id_i;
      rem_q    <= pe_vl_i;
      mask_q   <= pe_operand_i.mask;
      count_q  <= '0;
      hazard_q <= pe_hazard_i;
    end else begin
      hazard_q <= hazard_q & vinsn_running_i;
      if (busy_q && clear && rem_q != '0) begin
        count_q <= count_q + 32'(mask_q[0]);
        mask_q  <= mask_q >> 1;
        rem_q   <= rem_q - vlen_t'(1);
      end
    end
  end

endmodule

//--- vseq_sequencer.sv
`timescale 1ns/100ps

module vseq_sequencer (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  // Host request
  input  logic                                                req_valid_i,
  output logic                                                req_ready_o,
  input  vseq_pkg::vseq_op_e                                  req_op_i,
  input  vseq_pkg::vreg_t                                     req_vd_i,
  input  vseq_pkg::vreg_t                                     req_vs1_i,
  input  vseq_pkg::vreg_t                                     req_vs2_i,
  input  vseq_pkg::vlen_t                                     req_vl_i,
  input  vseq_pkg::vseq_operand_u                             req_operand_i,
  // Host response
  output logic                                                resp_valid_o,
  output logic [31:0]                                         resp_data_o,
  output logic                                                resp_error_o,
  output logic                                                idle_o,
  // Broadcast to the PEs
  output logic                                                pe_req_valid_o,
  output vseq_pkg::vseq_op_e                                  pe_op_o,
  output vseq_pkg::vid_t                                      pe_id_o,
  output vseq_pkg::vlen_t                                     pe_vl_o,
  output vseq_pkg::vseq_operand_u                             pe_operand_o,
  output logic [vseq_pkg::NR_VINSN-1:0]                       pe_hazard_o,
  output logic [vseq_pkg::NR_VINSN-1:0]                       vinsn_running_o,
  input  logic [vseq_pkg::NR_PES-1:0]                         pe_ready_i,
  input  logic [vseq_pkg::NR_PES-1:0][vseq_pkg::NR_VINSN-1:0] pe_done_i,
  // Unit responses
  input  logic                                                addr_ack_i,
  input  logic                                                addr_error_i,
  input  logic                                                scalar_valid_i,
  input  logic [31:0]                                         scalar_data_i
);

  import vseq_pkg::*;

  logic [NR_PES-1:0][NR_VINSN-1:0] pe_running_d, pe_running_q;
  logic [NR_VINSN-1:0]             running_d, running_q;

  // Last reader and last writer of each vector register
  vid_t [NR_VREGS-1:0] rd_vid_q, wr_vid_q;
  logic [NR_VREGS-1:0] rd_vld_q, wr_vld_q;
  logic [NR_VREGS-1:0] rd_live, wr_live;

  logic                wait_q;
  vid_t                free_id;
  logic                full, all_ready, hold, issue;
  logic                use_vs1, use_vs2, rd_vd, wr_vd;
  logic [NR_VINSN-1:0] haz_vs1, haz_vs2, haz_vd, haz_all;
  logic                haz_block;

  assign all_ready = &pe_ready_i;
  assign hold      = pe_req_valid_o && !all_ready;
  assign full      = &running_q;

  assign vinsn_running_o = running_q;
  assign idle_o          = !(|running_q);

  // Register use per op
  assign use_vs1 = req_op_i == VADD;
  assign use_vs2 = req_op_i inside {VADD, VPOPC};
  assign rd_vd   = req_op_i == VST;
  assign wr_vd   = req_op_i inside {VADD, VLD};

  // Lowest id that is not running
  always_comb begin
    free_id = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) free_id = vid_t'(i);
    end
  end

  // List entries expire once their instruction has finished
  always_comb begin
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_live[v] = rd_vld_q[v] && running_q[rd_vid_q[v]];
      wr_live[v] = wr_vld_q[v] && running_q[wr_vid_q[v]];
    end
  end

  ////////////////////
  // Hazards
  ////////////////////

  always_comb begin
    haz_vs1 = '0;
    haz_vs2 = '0;
    haz_vd  = '0;
    // RAW
    if (use_vs1 && wr_live[req_vs1_i]) haz_vs1[wr_vid_q[req_vs1_i]] = 1'b1;
    if (use_vs2 && wr_live[req_vs2_i]) haz_vs2[wr_vid_q[req_vs2_i]] = 1'b1;
    if (rd_vd && wr_live[req_vd_i]) haz_vd[wr_vid_q[req_vd_i]] = 1'b1;
    // WAR
    if (wr_vd && rd_live[req_vd_i]) haz_vd[rd_vid_q[req_vd_i]] = 1'b1;
    // WAW
    if (wr_vd && wr_live[req_vd_i]) haz_vd[wr_vid_q[req_vd_i]] = 1'b1;
  end

  assign haz_all = haz_vs1 | haz_vs2 | haz_vd;

  // Without a source operand no PE would stall, so the hazard is resolved here
  assign haz_block = !(use_vs1 || use_vs2 || rd_vd) && |haz_all;

  assign issue       = !wait_q && req_valid_i && all_ready && !full && !haz_block;
  assign req_ready_o = issue;

  ////////////////////
  // Running table
  ////////////////////

  always_comb begin
    pe_running_d = pe_running_q;
    for (int p = 0; p < NR_PES; p++) begin
      pe_running_d[p] &= ~pe_done_i[p];
    end
    if (issue) begin
      unique case (unit_of(req_op_i))
        UNIT_MEM:    pe_running_d[PE_MEM][free_id] = 1'b1;
        UNIT_SCALAR: pe_running_d[PE_SCALAR][free_id] = 1'b1;
        default: begin
          for (int l = 0; l < NR_LANES; l++) begin
            pe_running_d[l][free_id] = 1'b1;
          end
        end
      endcase
    end
    running_d = '0;
    for (int p = 0; p < NR_PES; p++) begin
      running_d |= pe_running_d[p];
    end
  end

  // Loads, stores and popcount respond through the memory or scalar unit
  assign resp_valid_o = wait_q && (addr_ack_i || scalar_valid_i);
  assign resp_data_o  = scalar_valid_i ? scalar_data_i : '0;
  assign resp_error_o = addr_ack_i && addr_error_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q         <= 1'b0;
      pe_running_q   <= '0;
      running_q      <= '0;
      rd_vld_q       <= '0;
      wr_vld_q       <= '0;
      pe_req_valid_o <= 1'b0;
    end else begin
      pe_running_q   <= pe_running_d;
      running_q      <= running_d;
      pe_req_valid_o <= issue || hold;
      if (issue && unit_of(req_op_i) != UNIT_LANES) begin
        wait_q <= 1'b1;
      end else if (resp_valid_o) begin
        wait_q <= 1'b0;
      end
      rd_vld_q <= rd_live;
      wr_vld_q <= wr_live;
      if (issue) begin
        if (wr_vd) wr_vld_q[req_vd_i] <= 1'b1;
        if (rd_vd) rd_vld_q[req_vd_i] <= 1'b1;
        if (use_vs1) rd_vld_q[req_vs1_i] <= 1'b1;
        if (use_vs2) rd_vld_q[req_vs2_i] <= 1'b1;
      end
    end
  end

  // Broadcast payload and hazards that shrink while the broadcast is held
  always_ff @(posedge clk_i) begin
    pe_hazard_o <= issue ? haz_all : (pe_hazard_o & running_d);
    if (issue) begin
      pe_op_o      <= req_op_i;
      pe_id_o      <= free_id;
      pe_vl_o      <= req_vl_i;
      pe_operand_o <= req_operand_i;
      if (wr_vd) wr_vid_q[req_vd_i] <= free_id;
      if (rd_vd) rd_vid_q[req_vd_i] <= free_id;
      if (use_vs1) rd_vid_q[req_vs1_i] <= free_id;
      if (use_vs2) rd_vid_q[req_vs2_i] <= free_id;
    end
  end

  // Every running id is still on the broadcast or held by a busy PE
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    |running_q |-> pe_req_valid_o || !all_ready);

  // A unit answers only while the FSM waits and never two at once
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (addr_ack_i || scalar_valid_i) |-> wait_q && !(addr_ack_i && scalar_valid_i));

endmodule

//--- vseq_top.sv
`timescale 1ns/100ps

module vseq_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  vseq_pkg::vseq_op_e       req_op_i,
  input  vseq_pkg::vreg_t          req_vd_i,
  input  vseq_pkg::vreg_t          req_vs1_i,
  input  vseq_pkg::vreg_t          req_vs2_i,
  input  vseq_pkg::vlen_t          req_vl_i,
  input  vseq_pkg::vseq_operand_u  req_operand_i,
  output logic                     resp_valid_o,
  output logic [31:0]              resp_data_o,
  output logic                     resp_error_o,
  output logic                     idle_o
);

  import vseq_pkg::*;

  // Broadcast
  logic          pe_req_valid;
  vseq_op_e      pe_op;
  vid_t          pe_id;
  vlen_t         pe_vl;
  vseq_operand_u pe_operand;
  logic [NR_VINSN-1:0] pe_hazard, vinsn_running;

  // PE status
  logic [NR_PES-1:0]               pe_ready;
  logic [NR_PES-1:0][NR_VINSN-1:0] pe_done;
  logic                            addr_ack, addr_error;
  logic                            scalar_valid;
  logic [31:0]                     scalar_data;

  vseq_sequencer u_sequencer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_op_i        (req_op_i),
    .req_vd_i        (req_vd_i),
    .req_vs1_i       (req_vs1_i),
    .req_vs2_i       (req_vs2_i),
    .req_vl_i        (req_vl_i),
    .req_operand_i   (req_operand_i),
    .resp_valid_o    (resp_valid_o),
    .resp_data_o     (resp_data_o),
    .resp_error_o    (resp_error_o),
    .idle_o          (idle_o),
    .pe_req_valid_o  (pe_req_valid),
    .pe_op_o         (pe_op),
    .pe_id_o         (pe_id),
    .pe_vl_o         (pe_vl),
    .pe_operand_o    (pe_operand),
    .pe_hazard_o     (pe_hazard),
    .vinsn_running_o (vinsn_running),
    .pe_ready_i      (pe_ready),
    .pe_done_i       (pe_done),
    .addr_ack_i      (addr_ack),
    .addr_error_i    (addr_error),
    .scalar_valid_i  (scalar_valid),
    .scalar_data_i   (scalar_data)
  );

  ////////////////////
  // Lanes
  ////////////////////

  for (genvar l = 0; l < NR_LANES; l++) begin : g_lane
    vseq_lane u_lane (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .pe_req_valid_i  (pe_req_valid),
      .pe_op_i         (pe_op),
      .pe_id_i         (pe_id),
      .pe_vl_i         (pe_vl),
      .pe_hazard_i     (pe_hazard),
      .vinsn_running_i (vinsn_running),
      .ready_o         (pe_ready[l]),
      .done_o          (pe_done[l])
    );
  end

  vseq_mem_unit u_mem_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_valid_i  (pe_req_valid),
    .pe_op_i         (pe_op),
    .pe_id_i         (pe_id),
    .pe_vl_i         (pe_vl),
    .pe_operand_i    (pe_operand),
    .pe_hazard_i     (pe_hazard),
    .vinsn_running_i (vinsn_running),
    .ready_o         (pe_ready[PE_MEM]),
    .done_o          (pe_done[PE_MEM]),
    .addr_ack_o      (addr_ack),
    .addr_error_o    (addr_error)
  );

  vseq_scalar_unit u_scalar_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_valid_i  (pe_req_valid),
    .pe_op_i         (pe_op),
    .pe_id_i         (pe_id),
    .pe_vl_i         (pe_vl),
    .pe_operand_i    (pe_operand),
    .pe_hazard_i     (pe_hazard),
    .vinsn_running_i (vinsn_running),
    .ready_o         (pe_ready[PE_SCALAR]),
    .done_o          (pe_done[PE_SCALAR]),
    .scalar_valid_o  (scalar_valid),
    .scalar_data_o   (scalar_data)
  );

endmodule

//--- tb_vseq.sv
`timescale 1ns/100ps

module tb_vseq;

  import vseq_pkg::*;

  localparam int unsigned TIMEOUT = 2000;

  logic          clk_i;
  logic          rst_ni;
  logic          req_valid_i;
  logic          req_ready_o;
  vseq_op_e      req_op_i;
  vreg_t         req_vd_i;
  vreg_t         req_vs1_i;
  vreg_t         req_vs2_i;
  vlen_t         req_vl_i;
  vseq_operand_u req_operand_i;
  logic          resp_valid_o;
  logic [31:0]   resp_data_o;
  logic          resp_error_o;
  logic          idle_o;

  logic [15:0] lfsr_q = 16'd35394;
  int unsigned cyc_q = 0;
  int unsigned err_cnt = 0;
  // Expected responses as {error, data} with the oldest first
  logic [32:0] exp_q[$];

  vseq_top u_vseq_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_vd_i      (req_vd_i),
    .req_vs1_i     (req_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_vl_i      (req_vl_i),
    .req_operand_i (req_operand_i),
    .resp_valid_o  (resp_valid_o),
    .resp_data_o   (resp_data_o),
    .resp_error_o  (resp_error_o),
    .idle_o        (idle_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc_q <= cyc_q + 1;

  ////////////////////
  // Helpers
  ////////////////////

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Popcount of the low vl mask bits, or the alignment error of a base
  function automatic logic [32:0] ref_resp(vseq_op_e op, vlen_t vl, vseq_operand_u operand);
    logic [31:0] cnt;
    logic        err;
    cnt = '0;
    err = 1'b0;
    if (op == VPOPC) begin
      for (int i = 0; i < 32; i++) begin
        if (i < int'(vl) && operand.mask[i]) cnt = cnt + 32'd1;
      end
    end else begin
      err = (operand.addr % ELEM_BYTES) != 0;
    end
    return {err, cnt};
  endfunction

  task automatic check(string name, logic [32:0] expected, logic [32:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  task automatic timeout_fail(string what);
    err_cnt++;
    $display("Timed out while waiting for %s", what);
    $display("CHECKS FAILED");
    $fatal(1, "Timeout");
  endtask

  // Presents one request and returns the cycle of its acceptance
  task automatic send(vseq_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, vlen_t vl,
                      logic [31:0] operand, output int unsigned acc_cyc);
    int unsigned t;
    req_op_i           = op;
    req_vd_i           = vd;
    req_vs1_i          = vs1;
    req_vs2_i          = vs2;
    req_vl_i           = vl;
    req_operand_i.addr = operand;
    req_valid_i        = 1'b1;
    t = 0;
    @(negedge clk_i);
    while (!req_ready_o && t < TIMEOUT) begin
      t++;
      @(negedge clk_i);
    end
    if (!req_ready_o) timeout_fail("req_ready_o");
    acc_cyc = cyc_q;
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    if (unit_of(op) != UNIT_LANES) exp_q.push_back(ref_resp(op, vl, req_operand_i));
  endtask

  // All responses in and every instruction retired
  task automatic wait_done();
    int unsigned t;
    t = 0;
    @(posedge clk_i);
    #1;
    while ((exp_q.size() != 0 || !idle_o) && t < TIMEOUT) begin
      t++;
      @(posedge clk_i);
      #1;
    end
    if (exp_q.size() != 0 || !idle_o) timeout_fail("the DUT to become idle");
    #1;
  endtask

  ////////////////////
  // Response monitor
  ////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      // No new request while a response is still owed
      if (exp_q.size() != 0) check("ready_while_waiting", 33'd0, 33'(req_ready_o));
      if (resp_valid_o) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("A response arrived while no instruction was waiting for one");
          $display("CHECKS FAILED");
          $fatal(1, "Unexpected response");
        end else begin
          check("response", exp_q.pop_front(), {resp_error_o, resp_data_o});
        end
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    vseq_op_e    op;
    logic [1:0]  op_bits;
    vlen_t       vl;
    vreg_t       vd;
    logic [31:0] opnd;
    int unsigned c_add;
    int unsigned c_ld;
    int unsigned share;
    rst_ni             = 1'b0;
    req_valid_i        = 1'b0;
    req_op_i           = VADD;
    req_vd_i           = '0;
    req_vs1_i          = '0;
    req_vs2_i          = '0;
    req_vl_i           = '0;
    req_operand_i.addr = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check("ready_after_reset", 33'd0, 33'(req_ready_o));
    check("resp_after_reset", 33'd0, 33'(resp_valid_o));
    check("idle_after_reset", 33'd1, 33'(idle_o));
    @(posedge clk_i);
    #2;

    // Popcount over random masks where vl may run past the word
    for (int n = 0; n < 12; n++) begin
      vl   = vlen_t'(rand_bits(6));
      opnd = rand_bits(32);
      send(VPOPC, 5'd0, 5'd0, vreg_t'(rand_bits(5)), vl, opnd, c_ld);
    end
    wait_done();

    // Loads and stores with random bases
    for (int n = 0; n < 12; n++) begin
      op   = rand_bits(1) != 0 ? VST : VLD;
      vd   = vreg_t'(rand_bits(5));
      vl   = vlen_t'(rand_bits(4));
      opnd = rand_bits(32);
      send(op, vd, 5'd0, 5'd0, vl, opnd, c_ld);
    end
    wait_done();

    // VADD then a VLD to the same vd that the WAW hazard holds back
    for (int n = 0; n < 4; n++) begin
      vd = vreg_t'(rand_bits(5));
      vl = vlen_t'(rand_bits(5)) + 8'd6;
      send(VADD, vd, vd + 5'd1, vd + 5'd2, vl, 32'd0, c_add);
      @(negedge clk_i);
      check("idle_after_vadd", 33'd0, 33'(idle_o));
      @(posedge clk_i);
      #2;
      send(VLD, vd, 5'd0, 5'd0, vl, rand_bits(30) << 2, c_ld);
      share = (int'(vl) + NR_LANES - 1) / NR_LANES;
      check("waw_hold", 33'd1, 33'(c_ld - c_add >= share));
      wait_done();
    end

    // Mixed traffic over few registers to force hazards
    for (int n = 0; n < 24; n++) begin
      op_bits = 2'(rand_bits(2));
      op      = vseq_op_e'(op_bits);
      vd      = vreg_t'(rand_bits(3));
      vl      = vlen_t'(rand_bits(5));
      opnd    = rand_bits(32);
      send(op, vd, vreg_t'(rand_bits(3)), vreg_t'(rand_bits(3)), vl, opnd, c_ld);
    end
    wait_done();

    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
vseq_pkg.sv
vseq_lane.sv
vseq_mem_unit.sv
vseq_scalar_unit.sv
vseq_sequencer.sv
vseq_top.sv
tb_vseq.sv

//--- run.sh
#!/bin/sh
# Compile the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_vseq -f tb.f -o sim_vseq \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_vseq > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
